// File: alu.sv
`timescale 1ns/1ns

module alu import rvCorePkg::*; (
    input logic [xlen-1:0] a,
    input logic [xlen-1:0] b,
    input aluOpT aluSel,
    output logic [xlen-1:0] result
);

    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = b[4:0];

    always_comb begin
        case (aluSel)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluSll: result = a << shamt;
            aluSlt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu: result = {{(xlen-1){1'b0}}, a < b};
            aluXor: result = a ^ b;
            aluSrl: result = a >> shamt;
            aluSra: result = $signed(a) >>> shamt;
            aluOr: result = a | b;
            aluAnd: result = a & b;
            aluPassB: result = b;
            default: result = '0;
        endcase
    end

    always_comb begin
        assert (aluSel inside {aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
                               aluSrl, aluSra, aluOr, aluAnd, aluPassB})
            else $error("alu: undefined operation code %0d", aluSel);
    end

endmodule

// File: branchUnit.sv
`timescale 1ns/1ns

module branchUnit import rvCorePkg::*; (
    input logic [xlen-1:0] rs1Data,
    input logic [xlen-1:0] rs2Data,
    input logic [xlen-1:0] pc,
    input logic [xlen-1:0] imm,
    input logic [xlen-1:0] aluResult,
    input logic [2:0] funct3,
    input ctrlT ctrl,
    output logic taken,
    output logic [xlen-1:0] nextPc
);

    logic condMet;

    always_comb begin
        case (funct3)
            3'b000: condMet = (rs1Data == rs2Data);
            3'b001: condMet = (rs1Data != rs2Data);
            3'b100: condMet = ($signed(rs1Data) < $signed(rs2Data));
            3'b101: condMet = ($signed(rs1Data) >= $signed(rs2Data));
            3'b110: condMet = (rs1Data < rs2Data);
            3'b111: condMet = (rs1Data >= rs2Data);
            default: condMet = 1'b0;
        endcase
    end

    assign taken = ctrl.jump | (ctrl.branch & condMet);

    // jalr target is rs1 + imm from the alu
    always_comb begin
        if (ctrl.jalr) begin
            nextPc = {aluResult[xlen-1:1], 1'b0};
        end else if (taken) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

endmodule

// File: controlUnit.sv
`timescale 1ns/1ns

module controlUnit import rvCorePkg::*; (
    input instrU inst,
    output ctrlT ctrl,
    output logic illegal
);

    logic isLui;
    logic isAuipc;
    logic isJal;
    logic isJalr;
    logic isBranch;
    logic isLoad;
    logic isStore;
    logic isImm;
    logic isReg;
    logic [2:0] funct3;
    logic altFunct;
    aluOpT riSel;
    aluOpT bSel;

    assign funct3 = inst.rType.funct3;
    // bit 5 of funct7 picks SUB and SRA
    assign altFunct = inst.rType.funct7[5];

    // opcode groups, all compared in parallel
    assign isLui = (inst.rType.opcode == opLui);
    assign isAuipc = (inst.rType.opcode == opAuipc);
    assign isJal = (inst.rType.opcode == opJal);
    assign isJalr = (inst.rType.opcode == opJalr);
    assign isBranch = (inst.rType.opcode == opBranch);
    assign isLoad = (inst.rType.opcode == opLoad);
    assign isStore = (inst.rType.opcode == opStore);
    assign isImm = (inst.rType.opcode == opImm);
    assign isReg = (inst.rType.opcode == opReg);

    // the all-zero word lands here too, its opcode is unknown
    assign illegal = ~(isLui | isAuipc | isJal | isJalr | isBranch |
                       isLoad | isStore | isImm | isReg);

    assign ctrl.immSel = isStore ? immS :
                         isBranch ? immB :
                         (isLui | isAuipc) ? immU :
                         isJal ? immJ : immI;

    assign ctrl.enWreg = isLui | isAuipc | isJal | isJalr | isLoad | isImm | isReg;
    assign ctrl.enWmem = isStore;
    assign ctrl.load = isLoad;
    assign ctrl.branch = isBranch;
    assign ctrl.jump = isJal | isJalr;
    assign ctrl.jalr = isJalr;

    assign ctrl.aSrc = (isAuipc | isJal) ? aSrcPc : aSrcRs1;
    assign ctrl.bSrc = isJal ? bSrcFour :
                       (isReg | isBranch) ? bSrcRs2 : bSrcImm;

    always_comb begin
        case (funct3)
            3'b000: riSel = (isReg && altFunct) ? aluSub : aluAdd;
            3'b001: riSel = aluSll;
            3'b010: riSel = aluSlt;
            3'b011: riSel = aluSltu;
            3'b100: riSel = aluXor;
            3'b101: riSel = altFunct ? aluSra : aluSrl;
            3'b110: riSel = aluOr;
            default: riSel = aluAnd;
        endcase
    end

    // beq/bne subtract, blt/bge signed compare, bltu/bgeu unsigned
    assign bSel = (funct3[2] & funct3[1]) ? aluSltu :
                  (funct3[2] ^ funct3[1]) ? aluSlt : aluSub;

    assign ctrl.aluSel = (isImm | isReg) ? riSel :
                         isBranch ? bSel :
                         isLui ? aluPassB : aluAdd;

    always_comb begin
        assert (!(ctrl.enWreg && ctrl.enWmem))
            else $error("controlUnit: register and memory write both enabled");
    end

endmodule

// File: immGen.sv
`timescale 1ns/1ns

module immGen import rvCorePkg::*; (
    input instrU inst,
    input immSelT immSel,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (immSel)
            immI: begin
                imm = {{20{inst.iType.imm11To0[11]}}, inst.iType.imm11To0};
            end
            immS: begin
                imm = {{20{inst.sType.imm11To5[6]}}, inst.sType.imm11To5,
                       inst.sType.imm4To0};
            end
            // branch offsets are in halfwords, bit 0 always zero
            immB: begin
                imm = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                       inst.bType.imm10To5, inst.bType.imm4To1, 1'b0};
            end
            immU: begin
                imm = {inst.uType.imm31To12, 12'b0};
            end
            immJ: begin
                imm = {{11{inst.jType.imm20}}, inst.jType.imm20, inst.jType.imm19To12,
                       inst.jType.imm11, inst.jType.imm10To1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ns

module regFile import rvCorePkg::*; (
    input logic clk,
    input logic rstN,
    input logic [regAddrW-1:0] rs1Addr,
    input logic [regAddrW-1:0] rs2Addr,
    input logic [regAddrW-1:0] rdAddr,
    input logic wrEn,
    input logic [xlen-1:0] wrData,
    output logic [xlen-1:0] rs1Data,
    output logic [xlen-1:0] rs2Data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rdAddr != '0)) begin
            regs[rdAddr] <= wrData;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    x0ReadsZero: assert property (
        @(posedge clk) disable iff (!rstN)
        ((rs1Addr != '0) || (rs1Data == '0)) &&
        ((rs2Addr != '0) || (rs2Data == '0))
    ) else $error("regFile: x0 read returned a nonzero value");

endmodule

// File: run.sh
#!/bin/sh
# build and run the rvExecCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbRvExecCore \
    -f rvExecCore.f -o simRvExecCore
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simRvExecCore > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "failures reported, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0

// File: rvCorePkg.sv
package rvCorePkg;

    localparam int xlen = 32;
    localparam int regAddrW = 5;

    // major opcodes
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;
    localparam logic [6:0] opJal = 7'b1101111;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] opReg = 7'b0110011;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immSelT;

    typedef enum logic {
        aSrcRs1 = 1'b0,
        aSrcPc = 1'b1
    } aSrcT;

    // 00 rs2, 01 immediate, 10 constant four
    typedef enum logic [1:0] {
        bSrcRs2 = 2'b00,
        bSrcImm = 2'b01,
        bSrcFour = 2'b10
    } bSrcT;

    typedef struct packed {
        immSelT immSel;
        logic enWreg;
        logic enWmem;
        logic load;
        logic branch;
        logic jump;
        logic jalr;
        aSrcT aSrc;
        bSrcT bSrc;
        aluOpT aluSel;
    } ctrlT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm11To0;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] imm11To5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4To0;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10To5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4To1;
        logic imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm31To12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } uTypeT;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10To1;
        logic imm11;
        logic [7:0] imm19To12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // one instruction word, seen through each encoding format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
        jTypeT jType;
    } instrU;

endpackage

// File: rvExecCore.f
rvCorePkg.sv
controlUnit.sv
immGen.sv
alu.sv
branchUnit.sv
regFile.sv
rvExecCore.sv
tbChecker.sv
tbRvExecCore.sv

// File: rvExecCore.sv
`timescale 1ns/1ns

module rvExecCore import rvCorePkg::*; (
    input logic clk,
    input logic rstN,
    input logic instValid,
    input instrU inst,
    input logic [xlen-1:0] pc,
    input logic [xlen-1:0] loadData,
    output logic memRead,
    output logic memWrite,
    output logic [xlen-1:0] memAddr,
    output logic [xlen-1:0] memWdata,
    output logic wbValid,
    output logic [regAddrW-1:0] wbRd,
    output logic [xlen-1:0] wbData,
    output logic [xlen-1:0] nextPc,
    output logic halted
);

    ctrlT ctrl;
    logic illegal;
    logic retire;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] pcPlus4;

    controlUnit uCtrl (
        .inst(inst),
        .ctrl(ctrl),
        .illegal(illegal)
    );

    immGen uImm (
        .inst(inst),
        .immSel(ctrl.immSel),
        .imm(imm)
    );

    regFile uRegs (
        .clk(clk),
        .rstN(rstN),
        .rs1Addr(inst.rType.rs1),
        .rs2Addr(inst.rType.rs2),
        .rdAddr(wbRd),
        .wrEn(wbValid),
        .wrData(wbData),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    assign opA = (ctrl.aSrc == aSrcPc) ? pc : rs1Data;

    always_comb begin
        case (ctrl.bSrc)
            bSrcImm: opB = imm;
            bSrcFour: opB = 32'd4;
            default: opB = rs2Data;
        endcase
    end

    alu uAlu (
        .a(opA),
        .b(opB),
        .aluSel(ctrl.aluSel),
        .result(aluResult)
    );

    branchUnit uBranch (
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .pc(pc),
        .imm(imm),
        .aluResult(aluResult),
        .funct3(inst.rType.funct3),
        .ctrl(ctrl),
        .taken(),
        .nextPc(nextPc)
    );

    // nothing retires once halted
    assign retire = instValid & ~halted & ~illegal;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (instValid && illegal) begin
            halted <= 1'b1;
        end
    end

    assign pcPlus4 = pc + 32'd4;

    assign memAddr = aluResult;
    assign memWdata = rs2Data;
    assign memRead = retire & ctrl.load;
    assign memWrite = retire & ctrl.enWmem;

    assign wbRd = inst.rType.rd;
    assign wbValid = retire & ctrl.enWreg & (wbRd != '0);
    assign wbData = ctrl.load ? loadData :
                    ctrl.jump ? pcPlus4 : aluResult;

    memExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(memRead && memWrite)
    ) else $error("rvExecCore: memRead and memWrite both high");

endmodule

// File: tbChecker.sv
`timescale 1ns/1ns

module tbChecker import rvCorePkg::*; (
    input logic clk,
    input logic rstN,
    input int testId,
    input logic instValid,
    input logic [31:0] inst,
    input logic [31:0] pc,
    input logic [31:0] loadData,
    input logic memRead,
    input logic memWrite,
    input logic [31:0] memAddr,
    input logic [31:0] memWdata,
    input logic wbValid,
    input logic [4:0] wbRd,
    input logic [31:0] wbData,
    input logic [31:0] nextPc,
    input logic halted,
    output int errorTotal
);

    typedef struct packed {
        logic illegal;
        logic memRead;
        logic memWrite;
        logic [31:0] memAddr;
        logic [31:0] memWdata;
        logic wbValid;
        logic [4:0] wbRd;
        logic [31:0] wbData;
        logic [31:0] nextPc;
    } expectT;

    string testNames [7] = '{"reset", "arith", "upperJump", "branch", "memory", "x0", "halt"};
    int testErrors [7];
    logic [31:0] shadow [32];
    logic expHalted;
    logic commitWb = 1'b0;
    logic commitHalt = 1'b0;
    logic [4:0] commitRd = 5'd0;
    logic [31:0] commitData = 32'h0;
    expectT want;

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
        logic [31:0] res;
        case (f3)
            3'b000: res = alt ? x - y : x + y;
            3'b001: res = x << y[4:0];
            3'b010: res = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011: res = (x < y) ? 32'd1 : 32'd0;
            3'b100: res = x ^ y;
            3'b110: res = x | y;
            3'b111: res = x & y;
            default: begin
                if (alt) begin
                    res = $signed(x) >>> y[4:0];
                end else begin
                    res = x >> y[4:0];
                end
            end
        endcase
        return res;
    endfunction

    // expected outputs of one instruction against the shadow registers
    function automatic expectT refModel(input logic [31:0] word, input logic [31:0] curPc,
                                        input logic [31:0] regs [32], input logic [31:0] ld);
        expectT e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] iImm;
        logic [31:0] sImm;
        logic [31:0] bImm;
        logic [31:0] uImm;
        logic [31:0] jImm;
        logic taken;
        a = regs[word[19:15]];
        b = regs[word[24:20]];
        iImm = {{20{word[31]}}, word[31:20]};
        sImm = {{20{word[31]}}, word[31:25], word[11:7]};
        bImm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        uImm = {word[31:12], 12'h000};
        jImm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        e = '0;
        e.nextPc = curPc + 32'd4;
        e.wbRd = word[11:7];
        case (word[6:0])
            opLui: e.wbData = uImm;
            opAuipc: e.wbData = curPc + uImm;
            opJal: begin
                e.wbData = curPc + 32'd4;
                e.nextPc = curPc + jImm;
            end
            opJalr: begin
                e.wbData = curPc + 32'd4;
                e.nextPc = (a + iImm) & ~32'd1;
            end
            opBranch: begin
                case (word[14:12])
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = ($signed(a) < $signed(b));
                    3'b101: taken = ($signed(a) >= $signed(b));
                    3'b110: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    e.nextPc = curPc + bImm;
                end
            end
            opLoad: begin
                e.memRead = 1'b1;
                e.memAddr = a + iImm;
                e.wbData = ld;
            end
            opStore: begin
                e.memWrite = 1'b1;
                e.memAddr = a + sImm;
                e.memWdata = b;
            end
            opImm: e.wbData = aluRef(word[14:12], word[30] && (word[14:12] == 3'b101), a, iImm);
            opReg: e.wbData = aluRef(word[14:12], word[30], a, b);
            default: e.illegal = 1'b1;
        endcase
        e.wbValid = !e.illegal && (word[6:0] != opBranch) && (word[6:0] != opStore) &&
                    (e.wbRd != 5'd0);
        return e;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %h, actual %h",
                     testNames[testId], what, expected, actual);
            testErrors[testId]++;
            errorTotal++;
        end
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %b, actual %b",
                     testNames[testId], what, expected, actual);
            testErrors[testId]++;
            errorTotal++;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            want = refModel(inst, pc, shadow, loadData);
            checkFlag("halted", expHalted, halted);
            commitWb = 1'b0;
            commitHalt = instValid && want.illegal;
            if (instValid && !expHalted && !want.illegal) begin
                checkFlag("memRead", want.memRead, memRead);
                checkFlag("memWrite", want.memWrite, memWrite);
                checkFlag("wbValid", want.wbValid, wbValid);
                checkValue("nextPc", want.nextPc, nextPc);
                if (want.memRead || want.memWrite) begin
                    checkValue("memAddr", want.memAddr, memAddr);
                end
                if (want.memWrite) begin
                    checkValue("memWdata", want.memWdata, memWdata);
                end
                if (want.wbValid) begin
                    checkValue("wbRd", {27'd0, want.wbRd}, {27'd0, wbRd});
                    checkValue("wbData", want.wbData, wbData);
                    commitWb = 1'b1;
                    commitRd = want.wbRd;
                    commitData = want.wbData;
                end
            end else begin
                checkFlag("memRead", 1'b0, memRead);
                checkFlag("memWrite", 1'b0, memWrite);
                checkFlag("wbValid", 1'b0, wbValid);
            end
        end
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= 32'h0;
            end
            expHalted <= 1'b0;
        end else begin
            if (commitWb) begin
                shadow[commitRd] <= commitData;
            end
            if (commitHalt) begin
                expHalted <= 1'b1;
            end
        end
    end

endmodule

// File: tbRvExecCore.sv
`timescale 1ns/1ns

module tbRvExecCore import rvCorePkg::*;;

    logic clk = 1'b0;
    logic rstN;
    logic instValid;
    logic [31:0] instWord;
    logic [31:0] curPc;
    logic [31:0] pcNext;
    logic [31:0] loadData;
    logic memRead;
    logic memWrite;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic wbValid;
    logic [4:0] wbRd;
    logic [31:0] wbData;
    logic [31:0] nextPc;
    logic halted;
    logic [31:0] rngState;
    int testId;
    int errorTotal;

    // branch operand pairs: equal, less, greater, signed/unsigned split
    logic [4:0] lhs [6] = '{5'd5, 5'd5, 5'd8, 5'd7, 5'd5, 5'd9};
    logic [4:0] rhs [6] = '{5'd6, 5'd8, 5'd5, 5'd5, 5'd7, 5'd8};
    logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    always #50 clk = ~clk;

    rvExecCore dut (
        .clk(clk),
        .rstN(rstN),
        .instValid(instValid),
        .inst(instWord),
        .pc(curPc),
        .loadData(loadData),
        .memRead(memRead),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .wbValid(wbValid),
        .wbRd(wbRd),
        .wbData(wbData),
        .nextPc(nextPc),
        .halted(halted)
    );

    tbChecker chk (
        .clk(clk),
        .rstN(rstN),
        .testId(testId),
        .instValid(instValid),
        .inst(instWord),
        .pc(curPc),
        .loadData(loadData),
        .memRead(memRead),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .wbValid(wbValid),
        .wbRd(wbRd),
        .wbData(wbData),
        .nextPc(nextPc),
        .halted(halted),
        .errorTotal(errorTotal)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // memory model, data depends on every address bit
    function automatic logic [31:0] addrHash(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[6:0], a[31:7]} ^ 32'h5a5a0f0f;
    endfunction

    assign loadData = memRead ? addrHash(memAddr) : 32'h0;

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // OP or OP-IMM with legal shift encodings
    function automatic logic [31:0] makeArith();
        logic [31:0] r;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        r = randWord();
        f3 = r[2:0];
        f7 = (r[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        imm = r[31:20];
        if (f3 == 3'b001) begin
            imm = {7'h00, r[24:20]};
        end else if (f3 == 3'b101) begin
            imm = {f7, r[24:20]};
        end
        if (r[4]) begin
            return encR(f7, r[9:5], r[14:10], f3, r[19:15]);
        end else begin
            return encI(imm, r[14:10], f3, r[19:15], opImm);
        end
    endfunction

    function automatic logic [31:0] makeUpperJump();
        logic [31:0] r;
        logic [31:0] w;
        r = randWord();
        case (r[1:0])
            2'd0: w = encU(r[31:12], r[11:7], opLui);
            2'd1: w = encU(r[31:12], r[11:7], opAuipc);
            2'd2: w = encJ({r[31:12], 1'b0}, r[11:7]);
            default: w = encI(r[31:20], r[19:15], 3'b000, r[11:7], opJalr);
        endcase
        return w;
    endfunction

    function automatic logic [31:0] makeMemory();
        logic [31:0] r;
        r = randWord();
        if (r[0]) begin
            return encS(r[31:20], r[9:5], r[14:10]);
        end else begin
            return encI(r[31:20], r[14:10], 3'b010, r[19:15], opLoad);
        end
    endfunction

    // one instruction per cycle, pc follows the reported nextPc
    task automatic issue(input logic [31:0] word);
        @(posedge clk);
        #5;
        instWord = word;
        curPc = pcNext;
        instValid = 1'b1;
        @(negedge clk);
        pcNext = nextPc;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #5;
            instValid = 1'b0;
        end
    endtask

    task automatic waitHalted(input int limit, output logic seen);
        int n;
        n = 0;
        while (!halted && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        seen = halted;
    endtask

    initial begin : stimulus
        logic [31:0] r;
        string line;
        logic haltSeen;
        rngState = 32'd53;
        rstN = 1'b0;
        instValid = 1'b0;
        instWord = 32'h0;
        curPc = 32'h1000;
        pcNext = 32'h1000;
        testId = 0;
        repeat (4) @(posedge clk);
        #5;
        rstN = 1'b1;

        // store data exposes each register straight after reset
        for (int i = 0; i < 32; i++) begin
            issue(encS(12'h0, i[4:0], 5'd0));
        end

        testId = 1;
        for (int i = 1; i < 32; i++) begin
            r = randWord();
            issue(encU(r[31:12], i[4:0], opLui));
            issue(encI(r[11:0], i[4:0], 3'b000, i[4:0], opImm));
        end
        repeat (200) issue(makeArith());

        testId = 2;
        repeat (80) issue(makeUpperJump());

        testId = 3;
        issue(encI(12'd5, 5'd0, 3'b000, 5'd5, opImm));
        issue(encI(12'd5, 5'd0, 3'b000, 5'd6, opImm));
        issue(encI(12'hffd, 5'd0, 3'b000, 5'd7, opImm));
        issue(encI(12'd7, 5'd0, 3'b000, 5'd8, opImm));
        issue(encU(20'h80000, 5'd9, opLui));
        for (int p = 0; p < 6; p++) begin
            for (int c = 0; c < 6; c++) begin
                r = randWord();
                issue(encB({r[12:1], 1'b0}, rhs[p], lhs[p], conds[c]));
            end
        end

        testId = 4;
        repeat (60) issue(makeMemory());
        // last memory word stays on inst while instValid is low
        idle(2);

        testId = 5;
        repeat (10) begin
            r = randWord();
            issue(encI(r[31:20], r[9:5], 3'b000, 5'd0, opImm));
            issue(encU(r[31:12], 5'd0, opLui));
            issue(encS(12'h0, 5'd0, 5'd0));
            issue(encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
        end

        testId = 6;
        issue(32'h0);
        waitHalted(1, haltSeen);
        if (!haltSeen) begin
            $display("timeout: halted did not rise after the all-zero word");
            $display("TEST RESULT: FAIL");
        end else begin
            repeat (5) issue(makeArith());
            repeat (5) issue(makeMemory());
            idle(2);

            line = "";
            for (int i = 0; i < 7; i++) begin
                line = {line, $sformatf(" %s=%0d", chk.testNames[i], chk.testErrors[i])};
            end
            $display("errors per test:%s total=%0d", line, errorTotal);
            if (errorTotal == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule
